//--- sources.f
hdl/umi_pkg.sv
hdl/umi_spram.sv
hdl/umi_atomic_alu.sv
hdl/umi_endpoint.sv
hdl/umi_mem_agent.sv
verification/umi_mem_agent_sva.sv
verification/tb_umi_mem_agent.sv

//--- verification/tb_umi_mem_agent.sv
// UMI memory agent testbench

`timescale 1ns/1ps
`default_nettype none

module tb_umi_mem_agent
   import umi_pkg::*;
();

   logic              clk;
   logic              nreset;
   logic              req_valid;
   umi_cmd_t          req_cmd;
   logic [umi_aw-1:0] req_dstaddr;
   logic [umi_aw-1:0] req_srcaddr;
   logic [umi_dw-1:0] req_data;
   logic              req_ready;
   logic              resp_valid;
   logic [umi_cw-1:0] resp_cmd;
   logic [umi_aw-1:0] resp_dstaddr;
   logic [umi_aw-1:0] resp_srcaddr;
   logic [umi_dw-1:0] resp_data;
   logic              resp_ready;

   logic [7:0]        ref_mem [ram_depth*umi_nbytes];  // Byte image of the RAM
   umi_cmd_t          exp_cmd_q [$];
   logic [umi_aw-1:0] exp_dst_q [$];
   logic [umi_aw-1:0] exp_src_q [$];
   logic [umi_dw-1:0] exp_data_q [$];
   int                n_issued = 0;
   int                n_resp = 0;
   logic              bp_on = 1'b0;

   umi_mem_agent dut (
      .clk          (clk),
      .nreset       (nreset),
      .req_valid    (req_valid),
      .req_cmd      (req_cmd),
      .req_dstaddr  (req_dstaddr),
      .req_srcaddr  (req_srcaddr),
      .req_data     (req_data),
      .req_ready    (req_ready),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .resp_ready   (resp_ready)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   // ####################
   // Reporting
   // ####################

   task automatic report_fail();
      $display("Test failures found");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic check_cmd(input string name, input umi_cmd_t exp, input umi_cmd_t act);
      if (act !== exp) begin
         $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
         report_fail();
      end
   endtask

   task automatic check_addr(input string name, input logic [umi_aw-1:0] exp,
                             input logic [umi_aw-1:0] act);
      if (act !== exp) begin
         $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
         report_fail();
      end
   endtask

   task automatic check_data(input string name, input logic [umi_dw-1:0] exp,
                             input logic [umi_dw-1:0] act);
      if (act !== exp) begin
         $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
         report_fail();
      end
   endtask

   // ####################
   // Reference model
   // ####################

   function automatic longint sign_ext(input logic [umi_dw-1:0] v, input int nb);
      case (nb)
         1:       return longint'($signed(v[7:0]));
         2:       return longint'($signed(v[15:0]));
         4:       return longint'($signed(v[31:0]));
         default: return longint'(v);
      endcase
   endfunction

   function automatic logic [umi_dw-1:0] atomic_ref(input logic [7:0] atype,
      input logic [umi_dw-1:0] old, input logic [umi_dw-1:0] op, input int nb);
      logic [umi_dw-1:0] mask;
      logic [umi_dw-1:0] uo;
      logic [umi_dw-1:0] up;
      mask = (nb == 8) ? '1 : ((64'd1 << (nb * 8)) - 64'd1);
      uo   = old & mask;
      up   = op & mask;
      case (atype)
         atype_add:  return (old + op) & mask;
         atype_and:  return uo & up;
         atype_or:   return uo | up;
         atype_xor:  return uo ^ up;
         atype_max:  return (sign_ext(up, nb) > sign_ext(uo, nb)) ? up : uo;
         atype_min:  return (sign_ext(up, nb) < sign_ext(uo, nb)) ? up : uo;
         atype_maxu: return (up > uo) ? up : uo;
         atype_minu: return (up < uo) ? up : uo;
         default:    return up;                   // Swap and unknown types
      endcase
   endfunction

   // Applies one request to the byte image and returns the expected response data
   function automatic logic [umi_dw-1:0] umi_expect(input umi_cmd_t cmd,
      input logic [umi_aw-1:0] addr, input logic [umi_dw-1:0] data);
      int                nb;
      int                base;
      logic [umi_dw-1:0] old;
      logic [umi_dw-1:0] upd;
      if (cmd.access.opcode == op_req_atomic)
         nb = 1 << cmd.atomic.size;
      else
         nb = (cmd.access.len + 1) << cmd.access.size;
      base = addr[ram_aw+umi_lane_w-1:0];
      old  = '0;
      for (int i = 0; i < nb; i++)
         old[i*8 +: 8] = ref_mem[base + i];
      case (cmd.access.opcode)
         op_req_write, op_req_posted: upd = data;
         op_req_atomic: upd = atomic_ref(cmd.atomic.atype, old, data, nb);
         default:       upd = old;
      endcase
      for (int i = 0; i < nb; i++)
         ref_mem[base + i] = upd[i*8 +: 8];
      if (cmd.access.opcode == op_req_write)
         return '0;
      return old;
   endfunction

   // ####################
   // Request driver
   // ####################

   task automatic send_req(input umi_cmd_t cmd, input logic [umi_aw-1:0] dst,
                           input logic [umi_aw-1:0] src, input logic [umi_dw-1:0] data);
      umi_cmd_t exp_c;
      @(negedge clk);
      req_valid   = 1'b1;
      req_cmd     = cmd;
      req_dstaddr = dst;
      req_srcaddr = src;
      req_data    = data;
      do @(posedge clk); while (!req_ready);   // Taken on this edge
      n_issued++;
      exp_c = '0;
      exp_c.access.opcode = (cmd.access.opcode == op_req_write) ? op_resp_write : op_resp_read;
      exp_c.access.size   = cmd.access.size;
      exp_c.access.len    = cmd.access.len;
      exp_data_q.push_back(umi_expect(cmd, dst, data));
      if (cmd.access.opcode == op_req_posted)
         void'(exp_data_q.pop_back());          // No response for posted writes
      else begin
         exp_cmd_q.push_back(exp_c);
         exp_dst_q.push_back(src);              // Addresses come back swapped
         exp_src_q.push_back(dst);
      end
   endtask

   task automatic issue(input logic [4:0] op, input logic [2:0] size, input logic [7:0] len,
                        input int offs);
      umi_cmd_t cmd;
      cmd = '0;
      cmd.access.opcode = op;
      cmd.access.size   = size;
      cmd.access.len    = len;
      send_req(cmd, ($urandom & 32'hffff_fe00) | offs, $urandom, {$urandom, $urandom});
   endtask

   task automatic pick_random(input logic [4:0] op, output logic [2:0] size,
                              output logic [7:0] len, output int offs);
      int nb;
      size = 3'($urandom % 4);
      if (op == op_req_atomic) begin
         len = 8'($urandom % 10);               // Type 9 exercises the swap default
         nb  = 1 << size;
      end else begin
         len = 8'($urandom % (8 >> size));
         nb  = (len + 1) << size;
      end
      offs = ($urandom % ram_depth) * 8 + $urandom % (9 - nb);
   endtask

   task automatic drain();
      @(negedge clk);
      req_valid = 1'b0;
      while (exp_cmd_q.size() != 0)
         @(posedge clk);
      repeat (5) @(posedge clk);                // Room for a stray response
   endtask

   // ####################
   // Tests
   // ####################

   task automatic fill_memory();
      for (int w = 0; w < ram_depth; w++)
         issue(op_req_write, 3'd3, 8'd0, w * 8);
      drain();
   endtask

   task automatic write_read_sweep();
      int nb;
      int w;
      for (int s = 0; s < 4; s++) begin
         for (int len = 0; len < (8 >> s); len++) begin
            nb = (len + 1) << s;
            for (int lane = 0; lane + nb <= 8; lane++) begin
               w = $urandom % ram_depth;
               issue(op_req_write, 3'(s), 8'(len), w * 8 + lane);
               issue(op_req_read, 3'(s), 8'(len), w * 8 + lane);
               issue(op_req_read, 3'd3, 8'd0, w * 8);  // Neighbour bytes kept
            end
         end
      end
      drain();
   endtask

   task automatic posted_then_read();
      logic [2:0] size;
      logic [7:0] len;
      int         offs;
      for (int i = 0; i < 16; i++) begin
         pick_random(op_req_posted, size, len, offs);
         issue(op_req_posted, size, len, offs);
         issue(op_req_read, size, len, offs);
      end
      drain();
   endtask

   task automatic atomic_sweep();
      int offs;
      for (int t = 0; t < 9; t++) begin
         for (int s = 0; s < 4; s++) begin
            offs = ($urandom % ram_depth) * 8 + $urandom % (9 - (1 << s));
            issue(op_req_atomic, 3'(s), 8'(t), offs);
            issue(op_req_read, 3'(s), 8'd0, offs);
         end
      end
      drain();
   endtask

   task automatic random_mix();
      logic [4:0] op;
      logic [2:0] size;
      logic [7:0] len;
      int         offs;
      bp_on = 1'b1;
      for (int i = 0; i < 200; i++) begin
         case ($urandom % 4)
            0:       op = op_req_read;
            1:       op = op_req_write;
            2:       op = op_req_posted;
            default: op = op_req_atomic;
         endcase
         pick_random(op, size, len, offs);
         issue(op, size, len, offs);
         if ($urandom % 5 == 0) begin
            @(negedge clk);
            req_valid = 1'b0;                   // Idle gap
         end
      end
      drain();
      bp_on = 1'b0;
   endtask

   // ####################
   // Response side
   // ####################

   always @(negedge clk)
      resp_ready = bp_on ? (($urandom % 3) != 0) : 1'b1;

   always @(posedge clk) begin
      if (nreset && resp_valid && resp_ready) begin
         if (exp_cmd_q.size() == 0) begin
            $display("A response arrived while no response was outstanding");
            report_fail();
         end else begin
            check_cmd("resp_cmd", exp_cmd_q.pop_front(), resp_cmd);
            check_addr("resp_dstaddr", exp_dst_q.pop_front(), resp_dstaddr);
            check_addr("resp_srcaddr", exp_src_q.pop_front(), resp_srcaddr);
            check_data("resp_data", exp_data_q.pop_front(), resp_data);
            n_resp++;
         end
      end
   end

   // Protocol violations from the bound checker
   always @(negedge clk) begin
      if (dut.u_sva.fail_count != 0) begin
         $display("The bound assertion checker flagged a protocol violation");
         report_fail();
      end
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles > 20 * n_issued + 200) begin
            $display("Watchdog expired, responses stopped arriving after %0d requests",
                     n_issued);
            report_fail();
         end
      end
   end

   initial begin
      void'($urandom(88960));
      nreset      = 1'b0;
      req_valid   = 1'b0;
      req_cmd     = '0;
      req_dstaddr = '0;
      req_srcaddr = '0;
      req_data    = '0;
      resp_ready  = 1'b1;
      repeat (5) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
      @(negedge clk);
      if (req_ready !== 1'b1 || resp_valid !== 1'b0) begin
         $display("Handshake outputs are not idle after reset");
         report_fail();
      end
      fill_memory();
      write_read_sweep();
      posted_then_read();
      atomic_sweep();
      random_mix();
      $display("%0d requests issued, %0d responses checked", n_issued, n_resp);
      if (dut.u_sva.fail_count == 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         $display("The bound assertion checker flagged a protocol violation");
         report_fail();
      end
   end

endmodule

`default_nettype wire

//--- verification/umi_mem_agent_sva.sv
// Memory agent handshake checks

`timescale 1ns/1ps
`default_nettype none

module umi_mem_agent_sva
   import umi_pkg::*;
(
   input wire logic              clk,
   input wire logic              nreset,
   input wire logic              req_valid,
   input wire logic              req_ready,
   input wire logic [umi_cw-1:0] req_cmd,
   input wire logic              resp_valid,
   input wire logic              resp_ready,
   input wire logic [umi_cw-1:0] resp_cmd,
   input wire logic [umi_aw-1:0] resp_dstaddr,
   input wire logic [umi_aw-1:0] resp_srcaddr,
   input wire logic [umi_dw-1:0] resp_data
);

   int       fail_count = 0;
   umi_cmd_t req_c;

   assign req_c = req_cmd;

   a_reset_idle: assert property (@(posedge clk) !nreset |-> !resp_valid)
      else begin
         $error("resp_valid high during reset");
         fail_count++;
      end

   // Stalled response keeps every field
   a_resp_hold: assert property (@(posedge clk) disable iff (!nreset)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp_cmd) &&
      $stable(resp_dstaddr) && $stable(resp_srcaddr) && $stable(resp_data))
      else begin
         $error("held response changed before it was taken");
         fail_count++;
      end

   a_atomic_stall: assert property (@(posedge clk) disable iff (!nreset)
      req_valid && req_ready && (req_c.access.opcode == op_req_atomic) |=> !req_ready)
      else begin
         $error("req_ready high in the cycle after an atomic");
         fail_count++;
      end

endmodule

bind umi_mem_agent umi_mem_agent_sva u_sva (
   .clk          (clk),
   .nreset       (nreset),
   .req_valid    (req_valid),
   .req_ready    (req_ready),
   .req_cmd      (req_cmd),
   .resp_valid   (resp_valid),
   .resp_ready   (resp_ready),
   .resp_cmd     (resp_cmd),
   .resp_dstaddr (resp_dstaddr),
   .resp_srcaddr (resp_srcaddr),
   .resp_data    (resp_data)
);

`default_nettype wire

//--- hdl/umi_mem_agent.sv
// UMI memory agent
// Byte-masked RAM behind a UMI device port

`timescale 1ns/1ps
`default_nettype none

module umi_mem_agent
   import umi_pkg::*;
(
   input  wire logic                clk,
   input  wire logic                nreset,
   // Request channel
   input  wire logic                req_valid,
   input  wire logic [umi_cw-1:0]   req_cmd,
   input  wire logic [umi_aw-1:0]   req_dstaddr,
   input  wire logic [umi_aw-1:0]   req_srcaddr,
   input  wire logic [umi_dw-1:0]   req_data,
   output logic                     req_ready,
   // Response channel
   output logic                     resp_valid,
   output logic [umi_cw-1:0]        resp_cmd,
   output logic [umi_aw-1:0]        resp_dstaddr,
   output logic [umi_aw-1:0]        resp_srcaddr,
   output logic [umi_dw-1:0]        resp_data,
   input  wire logic                resp_ready
);

   logic [umi_aw-1:0]     loc_addr;
   logic                  loc_read;
   logic                  loc_write;
   logic                  loc_atomic;
   logic [2:0]            loc_size;
   logic [umi_nb_w-1:0]   loc_nbytes;
   logic [7:0]            loc_atype;
   logic [umi_dw-1:0]     loc_wrdata;
   logic [umi_dw-1:0]     loc_rddata;
   logic                  loc_ready;

   logic [umi_lane_w-1:0] lane;
   logic [umi_nb_w:0]     lane_end;
   logic [umi_dw-1:0]     wr_mask;
   logic [umi_lane_w-1:0] rd_lane;

   // Atomic second cycle
   logic                  atom_active;
   logic [ram_aw-1:0]     atom_addr;
   logic [umi_dw-1:0]     atom_mask;
   logic [7:0]            atom_atype;
   logic [umi_dw-1:0]     atom_operand;
   logic [2:0]            atom_size;
   logic [umi_lane_w-1:0] atom_lane;
   logic [umi_nb_w-1:0]   atom_nbytes;
   logic [umi_dw-1:0]     alu_result;

   logic                  mem_we;
   logic [ram_aw-1:0]     mem_addr;
   logic [umi_dw-1:0]     mem_wmask;
   logic [umi_dw-1:0]     mem_din;
   logic [umi_dw-1:0]     mem_dout;

   umi_endpoint u_endpoint (
      .clk          (clk),
      .nreset       (nreset),
      .req_valid    (req_valid),
      .req_cmd      (req_cmd),
      .req_dstaddr  (req_dstaddr),
      .req_srcaddr  (req_srcaddr),
      .req_data     (req_data),
      .req_ready    (req_ready),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .resp_ready   (resp_ready),
      .loc_addr     (loc_addr),
      .loc_read     (loc_read),
      .loc_write    (loc_write),
      .loc_atomic   (loc_atomic),
      .loc_size     (loc_size),
      .loc_nbytes   (loc_nbytes),
      .loc_atype    (loc_atype),
      .loc_wrdata   (loc_wrdata),
      .loc_rddata   (loc_rddata),
      .loc_ready    (loc_ready)
   );

   // ####################
   // Lane mask
   // ####################

   assign lane     = loc_addr[umi_lane_w-1:0];
   assign lane_end = {2'b00, lane} + {1'b0, loc_nbytes};

   always_comb begin
      for (int i = 0; i < umi_nbytes; i++)
         wr_mask[i*8 +: 8] = {8{(i >= lane) && (i < lane_end)}};
   end

   // ####################
   // Atomic second cycle
   // ####################

   assign loc_ready   = ~atom_active;      // Stall while the result is written
   assign atom_nbytes = (atom_size > 3'd3) ? umi_nb_w'(umi_nbytes) :
                        umi_nb_w'(1) << atom_size;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         atom_active <= 1'b0;
      else
         atom_active <= loc_atomic;
   end

   always_ff @(posedge clk) begin
      if (loc_atomic) begin
         atom_addr    <= loc_addr[umi_lane_w +: ram_aw];
         atom_mask    <= wr_mask;
         atom_atype   <= loc_atype;
         atom_operand <= loc_wrdata;
         atom_size    <= loc_size;
         atom_lane    <= lane;
      end
      if (loc_read || loc_atomic)
         rd_lane <= lane;                  // Lane of the word now in dout
   end

   umi_atomic_alu u_atomic_alu (
      .atype    (atom_atype),
      .operand  (atom_operand),
      .old_data (loc_rddata),
      .nbytes   (atom_nbytes),
      .result   (alu_result)
   );

   // ####################
   // RAM port
   // ####################

   assign mem_we    = loc_write | atom_active;
   assign mem_addr  = atom_active ? atom_addr : loc_addr[umi_lane_w +: ram_aw];
   assign mem_wmask = atom_active ? atom_mask : wr_mask;
   assign mem_din   = atom_active ? (alu_result << {atom_lane, 3'b000}) :
                                    (loc_wrdata << {lane, 3'b000});

   umi_spram u_spram (
      .clk   (clk),
      .we    (mem_we),
      .addr  (mem_addr),
      .wmask (mem_wmask),
      .din   (mem_din),
      .dout  (mem_dout)
   );

   assign loc_rddata = mem_dout >> {rd_lane, 3'b000};  // Back to lane 0

endmodule

`default_nettype wire

//--- hdl/umi_endpoint.sv
// UMI device endpoint
// Request decode and response channel

`timescale 1ns/1ps
`default_nettype none

module umi_endpoint
   import umi_pkg::*;
(
   input  wire logic                clk,
   input  wire logic                nreset,
   // Request channel
   input  wire logic                req_valid,
   input  wire logic [umi_cw-1:0]   req_cmd,
   input  wire logic [umi_aw-1:0]   req_dstaddr,
   input  wire logic [umi_aw-1:0]   req_srcaddr,
   input  wire logic [umi_dw-1:0]   req_data,
   output logic                     req_ready,
   // Response channel
   output logic                     resp_valid,
   output logic [umi_cw-1:0]        resp_cmd,
   output logic [umi_aw-1:0]        resp_dstaddr,
   output logic [umi_aw-1:0]        resp_srcaddr,
   output logic [umi_dw-1:0]        resp_data,
   input  wire logic                resp_ready,
   // Memory side
   output logic [umi_aw-1:0]        loc_addr,
   output logic                     loc_read,
   output logic                     loc_write,
   output logic                     loc_atomic,
   output logic [2:0]               loc_size,
   output logic [umi_nb_w-1:0]      loc_nbytes,
   output logic [7:0]               loc_atype,
   output logic [umi_dw-1:0]        loc_wrdata,
   input  wire logic [umi_dw-1:0]   loc_rddata,
   input  wire logic                loc_ready
);

   umi_cmd_t              cmd_in;
   umi_cmd_t              rsp_hdr;
   logic [4:0]            opcode;
   logic                  is_atomic;
   logic                  is_write;
   logic                  is_posted;
   logic [15:0]           access_bytes;
   logic                  accept;
   logic                  out_free;
   logic                  advance;

   // Header stage that waits for the RAM read
   logic                  pend_valid;
   logic                  pend_hold;   // Data parked in hold_data
   umi_cmd_t              pend_cmd;
   logic [umi_aw-1:0]     pend_dstaddr;
   logic [umi_aw-1:0]     pend_srcaddr;
   logic [umi_nb_w-1:0]   pend_nbytes;
   logic                  pend_write;
   logic [umi_dw-1:0]     hold_data;
   logic [umi_dw-1:0]     pend_rddata;
   logic [umi_dw-1:0]     pend_masked;

   // ####################
   // Decode
   // ####################

   assign cmd_in    = req_cmd;
   assign opcode    = cmd_in.access.opcode;
   assign is_atomic = (opcode == op_req_atomic);
   assign is_write  = (opcode == op_req_write);
   assign is_posted = (opcode == op_req_posted);

   assign access_bytes = (16'(cmd_in.access.len) + 16'd1) << cmd_in.access.size;

   // Requests never cross a word, so the count saturates at one word
   always_comb begin
      if (is_atomic)
         loc_nbytes = (cmd_in.atomic.size > 3'd3) ? umi_nb_w'(umi_nbytes) :
                      umi_nb_w'(1) << cmd_in.atomic.size;
      else if (access_bytes > 16'(umi_nbytes))
         loc_nbytes = umi_nb_w'(umi_nbytes);
      else
         loc_nbytes = access_bytes[umi_nb_w-1:0];
   end

   always_comb begin
      rsp_hdr               = '0;
      rsp_hdr.access.opcode = is_write ? op_resp_write : op_resp_read;
      rsp_hdr.access.size   = cmd_in.access.size;
      rsp_hdr.access.len    = cmd_in.access.len;  // Atype byte for atomics
   end

   assign out_free  = ~resp_valid | resp_ready;
   assign req_ready = loc_ready & out_free;
   assign accept    = req_valid & req_ready;
   assign advance   = pend_valid & out_free;

   // One strobe per accepted request
   // Unknown opcodes are treated as reads
   assign loc_atomic = accept & is_atomic;
   assign loc_write  = accept & (is_write | is_posted);
   assign loc_read   = accept & ~is_atomic & ~is_write & ~is_posted;

   assign loc_addr   = req_dstaddr;
   assign loc_size   = cmd_in.access.size;
   assign loc_atype  = cmd_in.atomic.atype;
   assign loc_wrdata = req_data;

   // ####################
   // Response path
   // ####################

   assign pend_rddata = pend_hold ? hold_data : loc_rddata;

   always_comb begin
      for (int i = 0; i < umi_nbytes; i++) begin
         if ((i < pend_nbytes) && !pend_write)
            pend_masked[i*8 +: 8] = pend_rddata[i*8 +: 8];
         else
            pend_masked[i*8 +: 8] = 8'h00;
      end
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         pend_valid <= 1'b0;
         pend_hold  <= 1'b0;
         resp_valid <= 1'b0;
      end else begin
         if (accept)
            pend_valid <= ~is_posted;        // Posted writes end here
         else if (advance)
            pend_valid <= 1'b0;
         pend_hold <= pend_valid & ~out_free;
         if (out_free)
            resp_valid <= pend_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         pend_cmd     <= rsp_hdr;
         pend_dstaddr <= req_srcaddr;        // Addresses swap on return
         pend_srcaddr <= req_dstaddr;
         pend_nbytes  <= loc_nbytes;
         pend_write   <= is_write;
      end
      // RAM output only lasts one cycle
      if (pend_valid && !out_free && !pend_hold)
         hold_data <= loc_rddata;
      if (advance) begin
         resp_cmd     <= pend_cmd;
         resp_dstaddr <= pend_dstaddr;
         resp_srcaddr <= pend_srcaddr;
         resp_data    <= pend_masked;
      end
   end

endmodule

`default_nettype wire

//--- hdl/umi_atomic_alu.sv
// Atomic operation ALU

`timescale 1ns/1ps
`default_nettype none

module umi_atomic_alu
   import umi_pkg::*;
(
   input  wire logic [7:0]          atype,
   input  wire logic [umi_dw-1:0]   operand,   // Lane 0 aligned
   input  wire logic [umi_dw-1:0]   old_data,  // Lane 0 aligned
   input  wire logic [umi_nb_w-1:0] nbytes,
   output logic [umi_dw-1:0]        result
);

   logic [umi_nb_w-1:0] nb;
   logic [6:0]          sh;
   logic [umi_dw-1:0]   op_hi;
   logic [umi_dw-1:0]   old_hi;
   logic                gt_s;
   logic                gt_u;

   // Out of range counts compare the full word
   assign nb = ((nbytes == '0) || (nbytes > umi_nb_w'(umi_nbytes))) ?
               umi_nb_w'(umi_nbytes) : nbytes;

   // Move the top operand byte to the word MSB so the sign bit lines up
   assign sh     = 7'((umi_nbytes - nb) * 8);
   assign op_hi  = operand << sh;
   assign old_hi = old_data << sh;

   assign gt_s = $signed(op_hi) > $signed(old_hi);
   assign gt_u = op_hi > old_hi;

   always_comb begin
      case (atype)
         atype_add:  result = operand + old_data;
         atype_and:  result = operand & old_data;
         atype_or:   result = operand | old_data;
         atype_xor:  result = operand ^ old_data;
         atype_max:  result = gt_s ? operand : old_data;
         atype_min:  result = gt_s ? old_data : operand;
         atype_maxu: result = gt_u ? operand : old_data;
         atype_minu: result = gt_u ? old_data : operand;
         atype_swap: result = operand;
         default:    result = operand;        // Unknown types swap
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/umi_spram.sv
// Single-port RAM with bit write mask

`timescale 1ns/1ps
`default_nettype none

module umi_spram
   import umi_pkg::*;
(
   input  wire logic                clk,
   input  wire logic                we,
   input  wire logic [ram_aw-1:0]   addr,
   input  wire logic [umi_dw-1:0]   wmask,
   input  wire logic [umi_dw-1:0]   din,
   output logic [umi_dw-1:0]        dout
);

   logic [umi_dw-1:0] mem [ram_depth];

   // ####################
   // Write and read
   // ####################

   always_ff @(posedge clk) begin
      if (we)
         mem[addr] <= (mem[addr] & ~wmask) | (din & wmask);
   end

   // Old data on read-during-write
   always_ff @(posedge clk) begin
      dout <= mem[addr];
   end

endmodule

`default_nettype wire

//--- hdl/umi_pkg.sv
// UMI memory agent shared definitions

`default_nettype none

package umi_pkg;

   // ####################
   // Widths
   // ####################

   localparam int umi_dw     = 64;            // Data word
   localparam int umi_aw     = 32;            // Address
   localparam int umi_cw     = 32;            // Command
   localparam int umi_nbytes = umi_dw / 8;    // Bytes per word
   localparam int umi_lane_w = 3;             // Byte-lane offset
   localparam int umi_nb_w   = umi_lane_w + 1; // Byte count from 0 to 8

   localparam int ram_depth  = 64;
   localparam int ram_aw     = 6;

   // ####################
   // Opcodes
   // ####################

   // Requests
   localparam logic [4:0] op_req_read   = 5'd1;
   localparam logic [4:0] op_req_write  = 5'd3;
   localparam logic [4:0] op_req_posted = 5'd5;
   localparam logic [4:0] op_req_atomic = 5'd9;

   // Responses
   localparam logic [4:0] op_resp_read  = 5'd2;
   localparam logic [4:0] op_resp_write = 5'd4;

   // Atomic types
   // Anything above swap behaves as swap
   localparam logic [7:0] atype_add  = 8'h00;
   localparam logic [7:0] atype_and  = 8'h01;
   localparam logic [7:0] atype_or   = 8'h02;
   localparam logic [7:0] atype_xor  = 8'h03;
   localparam logic [7:0] atype_max  = 8'h04;  // Signed
   localparam logic [7:0] atype_min  = 8'h05;  // Signed
   localparam logic [7:0] atype_maxu = 8'h06;
   localparam logic [7:0] atype_minu = 8'h07;
   localparam logic [7:0] atype_swap = 8'h08;

   // ####################
   // Command word
   // ####################

   // Bits 15:8 hold a length for ordinary requests and the atomic type
   // for atomics while the rest of the layout is shared
   typedef union packed {
      struct packed {
         logic [15:0] reserved;
         logic [7:0]  len;
         logic [2:0]  size;
         logic [4:0]  opcode;
      } access;
      struct packed {
         logic [15:0] reserved;
         logic [7:0]  atype;
         logic [2:0]  size;
         logic [4:0]  opcode;
      } atomic;
   } umi_cmd_t;

endpackage

`default_nettype wire
